// ==== Makefile ====
# Verilator build and run for the data cache testbench.

VERILATOR ?= verilator
TOP ?= tb_cache
RTL_TOP ?= cache_subsystem
FILELIST ?= sources.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
FAIL_MSG ?= Regression failed
VFLAGS ?= --binary --timing --assert -Wno-fatal
LINT_FLAGS ?= --lint-only --timing

SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: build
	@./$(SIM_BIN) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "simulation reported failure, see $(LOG)"; exit 1; \
	fi

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== logic/cache_config.svh ====
`ifndef CACHE_CONFIG_SVH
`define CACHE_CONFIG_SVH

// a 32-bit byte address splits into tag, index and byte offset.
`define CACHE_ADDR_W 32
`define CACHE_TAG_W 20
`define CACHE_INDEX_W 8
`define CACHE_OFFSET_W 4

`define CACHE_WORD_W 32
`define CACHE_LINE_W 128
`define CACHE_LINES 256

// word select inside a line, taken from address bits 3:2.
`define CACHE_WSEL_W (`CACHE_OFFSET_W - 2)

`endif

// ==== logic/cache_controller.sv ====
`timescale 1ns/1ps
`include "cache_config.svh"

module cache_controller (
	input logic clk,
	input logic rst,
	cpu_req_if.ctrl req,
	line_xfer_if.ctrl xfer,
	output logic [`CACHE_INDEX_W-1:0] index,
	input logic [`CACHE_TAG_W-1:0] tag_rd,
	input logic valid_rd,
	input logic dirty_rd,
	input logic [`CACHE_LINE_W-1:0] line_rd,
	output logic word_we,
	output logic [`CACHE_WSEL_W-1:0] word_sel,
	output logic [`CACHE_WORD_W-1:0] word_wdata,
	output logic fill_we,
	output logic [`CACHE_TAG_W-1:0] fill_tag,
	output logic [`CACHE_LINE_W-1:0] fill_line,
	output logic inval_we
);

	cache_pkg::ctrl_state_e state;
	cache_pkg::ctrl_state_e next_state;
	cache_pkg::mem_op_e xfer_kind;
	logic [`CACHE_INDEX_W-1:0] flush_idx;
	logic [`CACHE_TAG_W-1:0] req_tag;
	logic [`CACHE_INDEX_W-1:0] req_index;
	logic [`CACHE_ADDR_W-1:0] xfer_addr;
	logic [`CACHE_WORD_W-1:0] rdata_q;
	logic flushing;
	logic last_idx;
	logic victim_dirty;
	logic hit;
	logic xfer_go;

	assign req_tag = req.addr[`CACHE_ADDR_W-1 -: `CACHE_TAG_W];
	assign req_index = req.addr[`CACHE_OFFSET_W +: `CACHE_INDEX_W];
	assign word_sel = req.addr[`CACHE_OFFSET_W-1 -: `CACHE_WSEL_W];
	assign word_wdata = req.wdata;

	assign flushing = (state == cache_pkg::ST_FLUSH_SCAN) || (state == cache_pkg::ST_FLUSH_WRITE);
	assign index = flushing ? flush_idx : req_index;
	assign last_idx = &flush_idx;

	assign hit = valid_rd && (tag_rd == req_tag);
	assign victim_dirty = valid_rd && dirty_rd;

	// a fill always comes from the line requested by the processor.
	assign fill_tag = req_tag;
	assign fill_line = xfer.rdata;

	assign req.done = (state == cache_pkg::ST_RESPOND);
	assign req.rdata = rdata_q;

	always_comb begin
		next_state = state;
		xfer_go = 1'b0;
		xfer_kind = cache_pkg::MEM_READ;
		xfer_addr = {req_tag, req_index, {`CACHE_OFFSET_W{1'b0}}};
		word_we = 1'b0;
		fill_we = 1'b0;
		inval_we = 1'b0;
		case (state)
			cache_pkg::ST_IDLE: begin
				if (req.start) begin
					if (req.op == cache_pkg::OP_FLUSH) begin
						next_state = cache_pkg::ST_FLUSH_SCAN;
					end else begin
						next_state = cache_pkg::ST_LOOKUP;
					end
				end
			end
			cache_pkg::ST_LOOKUP: begin
				if (hit) begin
					word_we = (req.op == cache_pkg::OP_WRITE);
					next_state = cache_pkg::ST_RESPOND;
				end else if (victim_dirty) begin
					// the victim goes back to its own address before the refill.
					xfer_go = 1'b1;
					xfer_kind = cache_pkg::MEM_WRITE;
					xfer_addr = {tag_rd, index, {`CACHE_OFFSET_W{1'b0}}};
					next_state = cache_pkg::ST_WRITE_BACK;
				end else begin
					xfer_go = 1'b1;
					next_state = cache_pkg::ST_ALLOCATE;
				end
			end
			cache_pkg::ST_WRITE_BACK: begin
				if (xfer.done) begin
					xfer_go = 1'b1;
					next_state = cache_pkg::ST_ALLOCATE;
				end
			end
			cache_pkg::ST_ALLOCATE: begin
				if (xfer.done) begin
					fill_we = 1'b1;
					next_state = cache_pkg::ST_LOOKUP;
				end
			end
			cache_pkg::ST_FLUSH_SCAN: begin
				if (victim_dirty) begin
					xfer_go = 1'b1;
					xfer_kind = cache_pkg::MEM_WRITE;
					xfer_addr = {tag_rd, index, {`CACHE_OFFSET_W{1'b0}}};
					next_state = cache_pkg::ST_FLUSH_WRITE;
				end else begin
					inval_we = 1'b1;
					if (last_idx) begin
						next_state = cache_pkg::ST_RESPOND;
					end
				end
			end
			cache_pkg::ST_FLUSH_WRITE: begin
				if (xfer.done) begin
					inval_we = 1'b1;
					next_state = last_idx ? cache_pkg::ST_RESPOND : cache_pkg::ST_FLUSH_SCAN;
				end
			end
			cache_pkg::ST_RESPOND: next_state = cache_pkg::ST_IDLE;
			default: next_state = cache_pkg::ST_IDLE;
		endcase
	end

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			state <= cache_pkg::ST_IDLE;
			flush_idx <= '0;
			xfer.start <= 1'b0;
		end else begin
			state <= next_state;
			xfer.start <= xfer_go;
			// the flush walk advances each time a line is invalidated.
			if (state == cache_pkg::ST_IDLE) begin
				flush_idx <= '0;
			end else if (inval_we) begin
				flush_idx <= flush_idx + 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (xfer_go) begin
			xfer.op <= xfer_kind;
			xfer.line_addr <= xfer_addr;
			xfer.wdata <= line_rd;
		end
		if (state == cache_pkg::ST_LOOKUP) begin
			rdata_q <= line_rd[word_sel*`CACHE_WORD_W +: `CACHE_WORD_W];
		end
	end

	a_word_aligned: assert property (@(posedge clk) disable iff (rst)
		req.start && (req.op != cache_pkg::OP_FLUSH) |-> (req.addr[1:0] == 2'b00));

endmodule

// ==== logic/cache_ifs.sv ====
`timescale 1ns/1ps
`include "cache_config.svh"

// one processor request from the processor port to the controller.
interface cpu_req_if;
	logic start;
	cache_pkg::cache_op_e op;
	logic [`CACHE_ADDR_W-1:0] addr;
	logic [`CACHE_WORD_W-1:0] wdata;
	logic done;
	logic [`CACHE_WORD_W-1:0] rdata;

	modport port (
		output start, op, addr, wdata,
		input done, rdata
	);

	modport ctrl (
		input start, op, addr, wdata,
		output done, rdata
	);
endinterface

// one line transfer from the controller to the memory port.
interface line_xfer_if;
	logic start;
	cache_pkg::mem_op_e op;
	logic [`CACHE_ADDR_W-1:0] line_addr;
	logic [`CACHE_LINE_W-1:0] wdata;
	logic done;
	logic [`CACHE_LINE_W-1:0] rdata;

	modport ctrl (
		output start, op, line_addr, wdata,
		input done, rdata
	);

	modport port (
		input start, op, line_addr, wdata,
		output done, rdata
	);
endinterface

// ==== logic/cache_pkg.sv ====
package cache_pkg;

	// processor operations.
	typedef enum logic [1:0] {
		OP_READ = 2'd0,
		OP_WRITE = 2'd1,
		OP_FLUSH = 2'd2
	} cache_op_e;

	// whole-line transfers to and from memory.
	typedef enum logic {
		MEM_READ = 1'b0,
		MEM_WRITE = 1'b1
	} mem_op_e;

	// cache controller states.
	typedef enum logic [2:0] {
		ST_IDLE = 3'd0,
		ST_LOOKUP = 3'd1,
		ST_WRITE_BACK = 3'd2,
		ST_ALLOCATE = 3'd3,
		ST_FLUSH_SCAN = 3'd4,
		ST_FLUSH_WRITE = 3'd5,
		ST_RESPOND = 3'd6
	} ctrl_state_e;

endpackage

// ==== logic/cache_subsystem.sv ====
`timescale 1ns/1ps
`include "cache_config.svh"

module cache_subsystem (
	input logic clk,
	input logic rst,
	input logic cpu_req,
	input cache_pkg::cache_op_e cpu_op,
	input logic [`CACHE_ADDR_W-1:0] cpu_addr,
	input logic [`CACHE_WORD_W-1:0] cpu_wdata,
	output logic cpu_ack,
	output logic [`CACHE_WORD_W-1:0] cpu_rdata,
	output logic mem_req,
	output cache_pkg::mem_op_e mem_op,
	output logic [`CACHE_ADDR_W-1:0] mem_addr,
	output logic [`CACHE_LINE_W-1:0] mem_wdata,
	input logic mem_ack,
	input logic [`CACHE_LINE_W-1:0] mem_rdata
);

	logic [`CACHE_INDEX_W-1:0] index;
	logic [`CACHE_TAG_W-1:0] tag_rd;
	logic valid_rd;
	logic dirty_rd;
	logic [`CACHE_LINE_W-1:0] line_rd;
	logic word_we;
	logic [`CACHE_WSEL_W-1:0] word_sel;
	logic [`CACHE_WORD_W-1:0] word_wdata;
	logic fill_we;
	logic [`CACHE_TAG_W-1:0] fill_tag;
	logic [`CACHE_LINE_W-1:0] fill_line;
	logic inval_we;

	cpu_req_if req_bus ();
	line_xfer_if xfer_bus ();

	cpu_port cpu_port_i (
		.clk(clk),
		.rst(rst),
		.cpu_req(cpu_req),
		.cpu_op(cpu_op),
		.cpu_addr(cpu_addr),
		.cpu_wdata(cpu_wdata),
		.cpu_ack(cpu_ack),
		.cpu_rdata(cpu_rdata),
		.req(req_bus.port)
	);

	cache_controller ctrl_i (
		.clk(clk),
		.rst(rst),
		.req(req_bus.ctrl),
		.xfer(xfer_bus.ctrl),
		.index(index),
		.tag_rd(tag_rd),
		.valid_rd(valid_rd),
		.dirty_rd(dirty_rd),
		.line_rd(line_rd),
		.word_we(word_we),
		.word_sel(word_sel),
		.word_wdata(word_wdata),
		.fill_we(fill_we),
		.fill_tag(fill_tag),
		.fill_line(fill_line),
		.inval_we(inval_we)
	);

	line_store store_i (
		.clk(clk),
		.rst(rst),
		.index(index),
		.tag_rd(tag_rd),
		.valid_rd(valid_rd),
		.dirty_rd(dirty_rd),
		.line_rd(line_rd),
		.word_we(word_we),
		.word_sel(word_sel),
		.word_wdata(word_wdata),
		.fill_we(fill_we),
		.fill_tag(fill_tag),
		.fill_line(fill_line),
		.inval_we(inval_we)
	);

	mem_port mem_port_i (
		.clk(clk),
		.rst(rst),
		.xfer(xfer_bus.port),
		.mem_req(mem_req),
		.mem_op(mem_op),
		.mem_addr(mem_addr),
		.mem_wdata(mem_wdata),
		.mem_ack(mem_ack),
		.mem_rdata(mem_rdata)
	);

endmodule

// ==== logic/cpu_port.sv ====
`timescale 1ns/1ps
`include "cache_config.svh"

module cpu_port (
	input logic clk,
	input logic rst,
	input logic cpu_req,
	input cache_pkg::cache_op_e cpu_op,
	input logic [`CACHE_ADDR_W-1:0] cpu_addr,
	input logic [`CACHE_WORD_W-1:0] cpu_wdata,
	output logic cpu_ack,
	output logic [`CACHE_WORD_W-1:0] cpu_rdata,
	cpu_req_if.port req
);

	typedef enum logic [1:0] {
		P_IDLE,
		P_BUSY,
		P_ACK
	} port_state_e;

	port_state_e state;
	logic req_q;

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			state <= P_IDLE;
			req_q <= 1'b0;
			req.start <= 1'b0;
			cpu_ack <= 1'b0;
		end else begin
			req_q <= cpu_req;
			req.start <= 1'b0;
			case (state)
				P_IDLE: begin
					if (req_q) begin
						req.start <= 1'b1;
						state <= P_BUSY;
					end
				end
				P_BUSY: begin
					if (req.done) begin
						cpu_ack <= 1'b1;
						state <= P_ACK;
					end
				end
				P_ACK: begin
					// the handshake closes once the processor has let go of req.
					if (!req_q) begin
						cpu_ack <= 1'b0;
						state <= P_IDLE;
					end
				end
				default: state <= P_IDLE;
			endcase
		end
	end

	// op, address and data are stable while cpu_req is high, so they are taken as they stand.
	always_ff @(posedge clk) begin
		if (state == P_IDLE && req_q) begin
			req.op <= cpu_op;
			req.addr <= cpu_addr;
			req.wdata <= cpu_wdata;
		end
		if (req.done) begin
			cpu_rdata <= req.rdata;
		end
	end

	a_req_held_until_ack: assert property (@(posedge clk) disable iff (rst)
		$fell(cpu_req) |-> cpu_ack);

endmodule

// ==== logic/line_store.sv ====
`timescale 1ns/1ps
`include "cache_config.svh"

module line_store (
	input logic clk,
	input logic rst,
	input logic [`CACHE_INDEX_W-1:0] index,
	output logic [`CACHE_TAG_W-1:0] tag_rd,
	output logic valid_rd,
	output logic dirty_rd,
	output logic [`CACHE_LINE_W-1:0] line_rd,
	input logic word_we,
	input logic [`CACHE_WSEL_W-1:0] word_sel,
	input logic [`CACHE_WORD_W-1:0] word_wdata,
	input logic fill_we,
	input logic [`CACHE_TAG_W-1:0] fill_tag,
	input logic [`CACHE_LINE_W-1:0] fill_line,
	input logic inval_we
);

	logic [`CACHE_TAG_W-1:0] tag_mem [`CACHE_LINES];
	logic [`CACHE_LINE_W-1:0] data_mem [`CACHE_LINES];
	logic [`CACHE_LINES-1:0] valid_bits;
	logic [`CACHE_LINES-1:0] dirty_bits;

	assign tag_rd = tag_mem[index];
	assign line_rd = data_mem[index];
	assign valid_rd = valid_bits[index];
	assign dirty_rd = dirty_bits[index];

	always_ff @(posedge clk) begin
		if (fill_we) begin
			tag_mem[index] <= fill_tag;
			data_mem[index] <= fill_line;
		end else if (word_we) begin
			data_mem[index][word_sel*`CACHE_WORD_W +: `CACHE_WORD_W] <= word_wdata;
		end
	end

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			valid_bits <= '0;
			dirty_bits <= '0;
		end else if (fill_we) begin
			valid_bits[index] <= 1'b1;
			dirty_bits[index] <= 1'b0;
		end else if (inval_we) begin
			valid_bits[index] <= 1'b0;
			dirty_bits[index] <= 1'b0;
		end else if (word_we) begin
			dirty_bits[index] <= 1'b1;
		end
	end

	a_fill_write_exclusive: assert property (@(posedge clk) disable iff (rst)
		!(fill_we && word_we));

endmodule

// ==== logic/mem_port.sv ====
`timescale 1ns/1ps
`include "cache_config.svh"

module mem_port (
	input logic clk,
	input logic rst,
	line_xfer_if.port xfer,
	output logic mem_req,
	output cache_pkg::mem_op_e mem_op,
	output logic [`CACHE_ADDR_W-1:0] mem_addr,
	output logic [`CACHE_LINE_W-1:0] mem_wdata,
	input logic mem_ack,
	input logic [`CACHE_LINE_W-1:0] mem_rdata
);

	typedef enum logic [1:0] {
		M_IDLE,
		M_REQ,
		M_RELEASE
	} mem_state_e;

	mem_state_e state;

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			state <= M_IDLE;
			mem_req <= 1'b0;
			xfer.done <= 1'b0;
		end else begin
			xfer.done <= 1'b0;
			case (state)
				M_IDLE: begin
					if (xfer.start) begin
						mem_req <= 1'b1;
						state <= M_REQ;
					end
				end
				M_REQ: begin
					// memory may stall for any number of cycles here.
					if (mem_ack) begin
						mem_req <= 1'b0;
						state <= M_RELEASE;
					end
				end
				M_RELEASE: begin
					if (!mem_ack) begin
						xfer.done <= 1'b1;
						state <= M_IDLE;
					end
				end
				default: state <= M_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (state == M_IDLE && xfer.start) begin
			mem_op <= xfer.op;
			mem_addr <= xfer.line_addr;
			mem_wdata <= xfer.wdata;
		end
		// memory holds its data until it sees mem_req fall.
		if (state == M_REQ && mem_ack) begin
			xfer.rdata <= mem_rdata;
		end
	end

	a_mem_payload_stable: assert property (@(posedge clk) disable iff (rst)
		mem_req && $past(mem_req) |-> $stable(mem_op) && $stable(mem_addr)
			&& $stable(mem_wdata));

endmodule

// ==== sources.f ====
+incdir+logic
logic/cache_pkg.sv
logic/cache_ifs.sv
logic/cpu_port.sv
logic/line_store.sv
logic/cache_controller.sv
logic/mem_port.sv
logic/cache_subsystem.sv
testbench/tb_memory_model.sv
testbench/tb_cache.sv

// ==== testbench/tb_cache.sv ====
`timescale 1ns/1ps
`include "cache_config.svh"

module tb_cache;

	localparam int ACK_TIMEOUT = 5000;

	logic clk = 1'b0;
	logic rst;
	logic cpu_req;
	cache_pkg::cache_op_e cpu_op;
	logic [`CACHE_ADDR_W-1:0] cpu_addr;
	logic [`CACHE_WORD_W-1:0] cpu_wdata;
	logic cpu_ack;
	logic [`CACHE_WORD_W-1:0] cpu_rdata;
	logic mem_req;
	cache_pkg::mem_op_e mem_op;
	logic [`CACHE_ADDR_W-1:0] mem_addr;
	logic [`CACHE_LINE_W-1:0] mem_wdata;
	logic mem_ack;
	logic [`CACHE_LINE_W-1:0] mem_rdata;

	// shadow holds one word per slot {tag[1:0], index[3:0], word[1:0]}.
	logic [`CACHE_WORD_W-1:0] shadow [256];
	bit written [256];
	logic [31:0] lfsr;
	bit hung;
	string pend_name;
	cache_pkg::cache_op_e pend_op;
	logic [`CACHE_WORD_W-1:0] pend_expect;
	logic ack_prev;
	logic mem_req_prev;
	int requests_issued = 0;
	int acks_seen = 0;
	int mem_reads = 0;
	int word_errors = 0;
	int line_errors = 0;
	int fill_errors = 0;
	int protocol_errors = 0;
	int timeout_errors = 0;

	always #2 clk = ~clk;

	cache_subsystem dut_i (
		.clk(clk),
		.rst(rst),
		.cpu_req(cpu_req),
		.cpu_op(cpu_op),
		.cpu_addr(cpu_addr),
		.cpu_wdata(cpu_wdata),
		.cpu_ack(cpu_ack),
		.cpu_rdata(cpu_rdata),
		.mem_req(mem_req),
		.mem_op(mem_op),
		.mem_addr(mem_addr),
		.mem_wdata(mem_wdata),
		.mem_ack(mem_ack),
		.mem_rdata(mem_rdata)
	);

	tb_memory_model mem_i (
		.clk(clk),
		.rst(rst),
		.mem_req(mem_req),
		.mem_op(mem_op),
		.mem_addr(mem_addr),
		.mem_wdata(mem_wdata),
		.mem_ack(mem_ack),
		.mem_rdata(mem_rdata)
	);

	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
	endfunction

	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] value;
		value = '0;
		for (int i = 0; i < n; i++) begin
			value = {value[30:0], lfsr[0]};
			lfsr = lfsr_step(lfsr);
		end
		return value;
	endfunction

	function automatic logic [7:0] word_slot(input logic [`CACHE_ADDR_W-1:0] addr);
		return {addr[13:12], addr[7:4], addr[3:2]};
	endfunction

	function automatic logic [`CACHE_ADDR_W-1:0] addr_of(input logic [7:0] slot);
		return {18'd0, slot[7:6], 4'd0, slot[5:2], slot[1:0], 2'd0};
	endfunction

	// a write lands in the shadow at once and a read returns what the shadow holds.
	function automatic logic [`CACHE_WORD_W-1:0] ref_access(input cache_pkg::cache_op_e op,
		input logic [`CACHE_ADDR_W-1:0] addr, input logic [`CACHE_WORD_W-1:0] wdata);
		logic [7:0] slot;
		slot = word_slot(addr);
		if (op == cache_pkg::OP_WRITE) begin
			shadow[slot] = wdata;
			written[slot] = 1'b1;
		end
		return shadow[slot];
	endfunction

	task automatic check_word(input string name, input logic [`CACHE_WORD_W-1:0] expected,
		input logic [`CACHE_WORD_W-1:0] actual);
		if (actual !== expected) begin
			word_errors++;
			$display("** Error %s: expected %h, actual %h", name, expected, actual);
		end
	endtask

	task automatic check_line(input string name, input logic [`CACHE_LINE_W-1:0] expected,
		input logic [`CACHE_LINE_W-1:0] actual);
		if (actual !== expected) begin
			line_errors++;
			$display("** Error %s: expected %h, actual %h", name, expected, actual);
		end
	endtask

	task automatic wait_ack(input logic level, input string name);
		int cycles;
		cycles = 0;
		while (cpu_ack !== level && cycles < ACK_TIMEOUT) begin
			@(posedge clk);
			cycles++;
		end
		if (cpu_ack !== level) begin
			hung = 1'b1;
			timeout_errors++;
			$display("%s: cpu_ack did not go to %0b within %0d cycles", name, level, ACK_TIMEOUT);
		end
	endtask

	task automatic do_request(input string name, input cache_pkg::cache_op_e op,
		input logic [`CACHE_ADDR_W-1:0] addr, input logic [`CACHE_WORD_W-1:0] wdata);
		if (hung) begin
			return;
		end
		@(posedge clk);
		#1;
		pend_name = $sformatf("%s at %h", name, addr);
		pend_op = op;
		pend_expect = ref_access(op, addr, wdata);
		requests_issued++;
		cpu_op = op;
		cpu_addr = addr;
		cpu_wdata = wdata;
		cpu_req = 1'b1;
		wait_ack(1'b1, pend_name);
		if (!hung) begin
			#1;
			cpu_req = 1'b0;
			wait_ack(1'b0, pend_name);
		end
	endtask

	task automatic load_shadow();
		for (int k = 0; k < 64; k++) begin
			for (int w = 0; w < 4; w++) begin
				shadow[k*4 + w] = mem_i.lines[k][w*`CACHE_WORD_W +: `CACHE_WORD_W];
				written[k*4 + w] = 1'b0;
			end
		end
	endtask

	task automatic reset_reads();
		logic [31:0] sel;
		for (int k = 0; k < 64; k++) begin
			sel = rand_bits(2);
			do_request("reset_read", cache_pkg::OP_READ, addr_of({k[5:0], sel[1:0]}), '0);
		end
	endtask

	task automatic write_reads();
		logic [31:0] slot;
		logic [31:0] data;
		for (int n = 0; n < 24; n++) begin
			slot = rand_bits(8);
			data = rand_bits(32);
			do_request("write_read", cache_pkg::OP_WRITE, addr_of(slot[7:0]), data);
			do_request("write_read", cache_pkg::OP_READ, addr_of(slot[7:0]), '0);
		end
	endtask

	task automatic random_mix();
		logic [31:0] kind;
		logic [31:0] slot;
		logic [31:0] data;
		for (int n = 0; n < 300; n++) begin
			kind = rand_bits(1);
			slot = rand_bits(8);
			data = rand_bits(32);
			do_request("random_mix", kind[0] ? cache_pkg::OP_WRITE : cache_pkg::OP_READ,
				addr_of(slot[7:0]), data);
		end
	endtask

	task automatic flush_and_verify();
		int fills_before;
		int lines_written;
		lines_written = 0;
		do_request("flush", cache_pkg::OP_FLUSH, '0, '0);
		if (!hung) begin
			for (int k = 0; k < 64; k++) begin
				check_line($sformatf("flush_line %0d", k),
					{shadow[k*4 + 3], shadow[k*4 + 2], shadow[k*4 + 1], shadow[k*4]},
					mem_i.lines[k]);
			end
		end
		for (int k = 0; k < 64; k++) begin
			if (written[k*4] || written[k*4 + 1] || written[k*4 + 2] || written[k*4 + 3]) begin
				lines_written++;
			end
		end
		fills_before = mem_reads;
		// every refetch has to miss, since the flush left the cache empty.
		for (int s = 0; s < 256; s++) begin
			if (written[s]) begin
				do_request("post_flush_read", cache_pkg::OP_READ, addr_of(s[7:0]), '0);
			end
		end
		// lines are revisited in slot order, so each written line is fetched exactly once.
		if (!hung && (mem_reads - fills_before) != lines_written) begin
			fill_errors++;
			$display("** Error post_flush_fills: expected %0d, actual %0d", lines_written,
				mem_reads - fills_before);
		end
	endtask

	always @(posedge clk) begin
		if (!rst) begin
			if (cpu_ack && !ack_prev) begin
				acks_seen++;
				if (!cpu_req) begin
					protocol_errors++;
					$display("cpu_ack rose at %0t while cpu_req was low", $time);
				end
				if (pend_op == cache_pkg::OP_READ) begin
					check_word(pend_name, pend_expect, cpu_rdata);
				end
			end
			if (mem_req && !mem_req_prev && mem_ack) begin
				protocol_errors++;
				$display("mem_req rose at %0t before the previous mem_ack fell", $time);
			end
			if (mem_req && !mem_req_prev && mem_op == cache_pkg::MEM_READ) begin
				mem_reads++;
			end
		end
		ack_prev = cpu_ack;
		mem_req_prev = mem_req;
	end

	initial begin
		int total;
		rst = 1'b1;
		cpu_req = 1'b0;
		cpu_op = cache_pkg::OP_READ;
		cpu_addr = '0;
		cpu_wdata = '0;
		lfsr = 32'd42;
		hung = 1'b0;
		repeat (8) @(posedge clk);
		#1;
		rst = 1'b0;
		load_shadow();
		reset_reads();
		write_reads();
		random_mix();
		flush_and_verify();
		repeat (4) @(posedge clk);
		total = word_errors + line_errors + fill_errors + protocol_errors + timeout_errors
			+ mem_i.bad_accesses;
		if (requests_issued != acks_seen) begin
			total++;
			$display("%0d requests were issued but %0d acks were seen", requests_issued, acks_seen);
		end
		$display("errors: word %0d, line %0d, fill %0d, protocol %0d, timeout %0d, memory %0d",
			word_errors, line_errors, fill_errors, protocol_errors, timeout_errors,
			mem_i.bad_accesses);
		if (total == 0) begin
			$display("Regression passed");
		end else begin
			$display("Regression failed");
		end
		$finish;
	end

endmodule

// ==== testbench/tb_memory_model.sv ====
`timescale 1ns/1ps
`include "cache_config.svh"

// the 64 lines cover tags 0 to 3 at indices 0 to 15, so a legal line address
// maps to slot {tag[1:0], index[3:0]}.
module tb_memory_model (
	input logic clk,
	input logic rst,
	input logic mem_req,
	input cache_pkg::mem_op_e mem_op,
	input logic [`CACHE_ADDR_W-1:0] mem_addr,
	input logic [`CACHE_LINE_W-1:0] mem_wdata,
	output logic mem_ack,
	output logic [`CACHE_LINE_W-1:0] mem_rdata
);

	typedef enum logic [1:0] {
		MM_IDLE,
		MM_DELAY,
		MM_ACK
	} model_state_e;

	logic [`CACHE_LINE_W-1:0] lines [64];
	logic [`CACHE_LINE_W-1:0] fill;
	model_state_e state;
	logic [2:0] delay_left;
	logic [31:0] lfsr = 32'd42;
	logic [31:0] pick;
	bit preloaded;
	int bad_accesses = 0;

	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
	endfunction

	// one LFSR step for every bit shifted into the result.
	function automatic logic [31:0] next_bits(input int n);
		logic [31:0] value;
		value = '0;
		for (int i = 0; i < n; i++) begin
			value = {value[30:0], lfsr[0]};
			lfsr = lfsr_step(lfsr);
		end
		return value;
	endfunction

	function automatic logic in_range(input logic [`CACHE_ADDR_W-1:0] addr);
		return (addr[31:14] == '0) && (addr[11:8] == '0) && (addr[3:0] == '0);
	endfunction

	function automatic logic [5:0] slot_of(input logic [`CACHE_ADDR_W-1:0] addr);
		return {addr[13:12], addr[7:4]};
	endfunction

	always @(posedge clk or posedge rst) begin
		if (rst) begin
			state <= MM_IDLE;
			mem_ack <= 1'b0;
			mem_rdata <= '0;
			delay_left <= '0;
			if (!preloaded) begin
				for (int k = 0; k < 64; k++) begin
					for (int w = 0; w < 4; w++) begin
						fill[w*`CACHE_WORD_W +: `CACHE_WORD_W] = next_bits(32);
					end
					lines[k] <= fill;
				end
				preloaded <= 1'b1;
			end
		end else begin
			case (state)
				MM_IDLE: begin
					if (mem_req) begin
						pick = next_bits(3);
						delay_left <= pick[2:0];
						state <= MM_DELAY;
					end
				end
				MM_DELAY: begin
					if (delay_left == 3'd0) begin
						if (!in_range(mem_addr)) begin
							bad_accesses++;
							$display("memory model: line address %h lies outside the test lines",
								mem_addr);
						end else if (mem_op == cache_pkg::MEM_WRITE) begin
							lines[slot_of(mem_addr)] <= mem_wdata;
						end else begin
							mem_rdata <= lines[slot_of(mem_addr)];
						end
						mem_ack <= 1'b1;
						state <= MM_ACK;
					end else begin
						delay_left <= delay_left - 3'd1;
					end
				end
				MM_ACK: begin
					if (!mem_req) begin
						mem_ack <= 1'b0;
						state <= MM_IDLE;
					end
				end
				default: state <= MM_IDLE;
			endcase
		end
	end

endmodule
